// ==== source/fp_pkg.sv ====
// IEEE 754 single precision format
// field types, the unpacked operand record and the unpack function

package fp_pkg;

  localparam int EXP_BIAS = 127;
  localparam logic [7:0] EXP_MAX = 8'hff;
  localparam int MANT_W = 23;

  typedef struct packed {
    logic              sign;
    logic [7:0]        exp;
    logic [MANT_W-1:0] frac;
  } fp_word_t;

  // unbiased exponent, wide enough to hold overflow and deep underflow
  typedef logic signed [9:0] exp_t;

  // mantissa with the hidden bit on top
  typedef logic [MANT_W:0] mant_t;

  typedef struct packed {
    logic  sign;
    exp_t  exp;
    mant_t mant;
    logic  zero;
    logic  inf;
    logic  nan;
  } fp_unpacked_t;

  localparam fp_word_t QNAN = 32'hffc00000;

  function automatic fp_unpacked_t fp_unpack(fp_word_t w);
    fp_unpacked_t u;
    u.sign = w.sign;
    u.nan  = (w.exp == EXP_MAX) && (w.frac != '0);
    u.inf  = (w.exp == EXP_MAX) && (w.frac == '0);
    u.zero = (w.exp == '0) && (w.frac == '0);
    // denormals sit at the minimum exponent without a hidden bit
    if (w.exp == '0) begin
      u.exp  = exp_t'(1 - EXP_BIAS);
      u.mant = {1'b0, w.frac};
    end else begin
      u.exp  = exp_t'(int'(w.exp) - EXP_BIAS);
      u.mant = {1'b1, w.frac};
    end
    return u;
  endfunction

endpackage

// ==== source/fpu_ctrl_pkg.sv ====
// FPU control encodings
// opcodes and the state sets of the two cores and the round stage

package fpu_ctrl_pkg;

  typedef enum logic {
    op_add,
    op_mul
  } fpu_op_e;

  typedef enum logic [2:0] {
    add_idle, add_special, add_align, add_sum, add_split, add_req
  } add_state_e;

  typedef enum logic [2:0] {
    mul_idle, mul_special, mul_norm, mul_product, mul_split, mul_req
  } mul_state_e;

  // round stage, gnt only offered in rp_idle
  typedef enum logic [2:0] {
    rp_idle,
    rp_norm_up,
    rp_norm_down,
    rp_round,
    rp_pack,
    rp_put
  } rp_state_e;

endpackage

// ==== source/fp_result_if.sv ====
// unrounded result link from a core towards the shared round stage
`timescale 1ns/1ps

interface fp_result_if import fp_pkg::*; #(
  parameter int TAG_W = 4
) ();

  logic             req;
  logic             gnt;
  logic             special;
  fp_word_t         special_word;
  logic             sign;
  exp_t             exp;
  mant_t            mant;
  logic             guard;
  logic             round_bit;
  logic             sticky;
  logic [TAG_W-1:0] tag;

  modport core (
    output req, special, special_word, sign, exp, mant, guard, round_bit, sticky, tag,
    input  gnt
  );

  modport arb (
    input  req, special, special_word, sign, exp, mant, guard, round_bit, sticky, tag,
    output gnt
  );

  // round stage end of the merged link
  modport rnd (
    input  req, special, special_word, sign, exp, mant, guard, round_bit, sticky, tag,
    output gnt
  );

endinterface

// ==== source/fp_add_core.sv ====
// single precision add core
// special cases, exponent alignment and signed mantissa add, result left unrounded
`timescale 1ns/1ps

module fp_add_core import fp_pkg::*, fpu_ctrl_pkg::*; #(
  parameter int TAG_W = 4
) (
  input  logic             clk,
  input  logic             rst,
  input  logic             start,
  input  fp_word_t         a,
  input  fp_word_t         b,
  input  logic [TAG_W-1:0] tag,
  output logic             idle,
  fp_result_if.core        res
);

  add_state_e   state;
  fp_word_t     a_w, b_w;
  fp_unpacked_t ua, ub;
  logic [26:0]  a_m, b_m;
  exp_t         a_e, b_e, z_e;
  logic         a_s, b_s, z_s;
  logic [27:0]  sum;

  assign ua = fp_unpack(a_w);
  assign ub = fp_unpack(b_w);
  assign idle = (state == add_idle);

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= add_idle;
      res.req <= 1'b0;
    end else begin
      case (state)
        add_idle: begin
          if (start) begin
            a_w <= a;
            b_w <= b;
            res.tag <= tag;
            state <= add_special;
          end
        end
        add_special: begin
          res.special <= 1'b1;
          res.req <= 1'b1;
          state <= add_req;
          if (ua.nan || ub.nan) begin
            res.special_word <= QNAN;
          end else if (ua.inf) begin
            res.special_word <= {ua.sign, EXP_MAX, {MANT_W{1'b0}}};
          end else if (ub.inf) begin
            res.special_word <= {ub.sign, EXP_MAX, {MANT_W{1'b0}}};
          end else if (ua.zero && ub.zero) begin
            res.special_word <= {ua.sign & ub.sign, 31'd0};
          end else if (ua.zero) begin
            res.special_word <= b_w;
          end else if (ub.zero) begin
            res.special_word <= a_w;
          end else begin
            res.special <= 1'b0;
            res.req <= 1'b0;
            a_m <= {ua.mant, 3'b000};
            b_m <= {ub.mant, 3'b000};
            a_e <= ua.exp;
            b_e <= ub.exp;
            a_s <= ua.sign;
            b_s <= ub.sign;
            state <= add_align;
          end
        end
        // shift the smaller operand right, lsb keeps the sticky OR
        // once only the sticky bit is left, jump straight to the other exponent
        add_align: begin
          if (a_e > b_e) begin
            b_e <= (b_m[26:1] == '0) ? a_e : b_e + 10'sd1;
            b_m <= {1'b0, b_m[26:2], b_m[1] | b_m[0]};
          end else if (a_e < b_e) begin
            a_e <= (a_m[26:1] == '0) ? b_e : a_e + 10'sd1;
            a_m <= {1'b0, a_m[26:2], a_m[1] | a_m[0]};
          end else begin
            state <= add_sum;
          end
        end
        add_sum: begin
          z_e <= a_e;
          if (a_s == b_s) begin
            sum <= a_m + b_m;
            z_s <= a_s;
          end else if (a_m >= b_m) begin
            sum <= a_m - b_m;
            // exact cancellation gives +0
            z_s <= (a_m == b_m) ? 1'b0 : a_s;
          end else begin
            sum <= b_m - a_m;
            z_s <= b_s;
          end
          state <= add_split;
        end
        add_split: begin
          res.sign <= z_s;
          if (sum[27]) begin
            res.mant <= sum[27:4];
            res.guard <= sum[3];
            res.round_bit <= sum[2];
            res.sticky <= sum[1] | sum[0];
            res.exp <= z_e + 10'sd1;
          end else begin
            res.mant <= sum[26:3];
            res.guard <= sum[2];
            res.round_bit <= sum[1];
            res.sticky <= sum[0];
            res.exp <= z_e;
          end
          res.special <= 1'b0;
          res.req <= 1'b1;
          state <= add_req;
        end
        add_req: begin
          if (res.gnt) begin
            res.req <= 1'b0;
            state <= add_idle;
          end
        end
        default: state <= add_idle;
      endcase
    end
  end

endmodule

// ==== source/fp_mul_core.sv ====
// single precision multiply core
// special cases, denormal pre-normalise and the 24x24 mantissa product
`timescale 1ns/1ps

module fp_mul_core import fp_pkg::*, fpu_ctrl_pkg::*; #(
  parameter int TAG_W = 4
) (
  input  logic             clk,
  input  logic             rst,
  input  logic             start,
  input  fp_word_t         a,
  input  fp_word_t         b,
  input  logic [TAG_W-1:0] tag,
  output logic             idle,
  fp_result_if.core        res
);

  mul_state_e   state;
  fp_word_t     a_w, b_w;
  fp_unpacked_t ua, ub;
  logic         z_s;
  mant_t        a_m, b_m;
  exp_t         a_e, b_e;
  logic [47:0]  product;

  assign ua = fp_unpack(a_w);
  assign ub = fp_unpack(b_w);
  assign z_s = ua.sign ^ ub.sign;
  assign idle = (state == mul_idle);

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= mul_idle;
      res.req <= 1'b0;
    end else begin
      case (state)
        mul_idle: begin
          if (start) begin
            a_w <= a;
            b_w <= b;
            res.tag <= tag;
            state <= mul_special;
          end
        end
        mul_special: begin
          res.sign <= z_s;
          res.special <= 1'b1;
          res.req <= 1'b1;
          state <= mul_req;
          // inf * 0 is invalid in either order
          if (ua.nan || ub.nan || (ua.inf && ub.zero) || (ua.zero && ub.inf)) begin
            res.special_word <= QNAN;
          end else if (ua.inf || ub.inf) begin
            res.special_word <= {z_s, EXP_MAX, {MANT_W{1'b0}}};
          end else if (ua.zero || ub.zero) begin
            res.special_word <= {z_s, 31'd0};
          end else begin
            res.special <= 1'b0;
            res.req <= 1'b0;
            a_m <= ua.mant;
            b_m <= ub.mant;
            a_e <= ua.exp;
            b_e <= ub.exp;
            state <= mul_norm;
          end
        end
        // bring denormals up to a set hidden bit, both in parallel
        mul_norm: begin
          if (!a_m[MANT_W]) begin
            a_m <= a_m << 1;
            a_e <= a_e - 10'sd1;
          end
          if (!b_m[MANT_W]) begin
            b_m <= b_m << 1;
            b_e <= b_e - 10'sd1;
          end
          if (a_m[MANT_W] && b_m[MANT_W]) begin
            state <= mul_product;
          end
        end
        mul_product: begin
          product <= a_m * b_m;
          // product msb carries weight 2^1
          res.exp <= a_e + b_e + 10'sd1;
          state <= mul_split;
        end
        mul_split: begin
          res.mant <= product[47:24];
          res.guard <= product[23];
          res.round_bit <= product[22];
          res.sticky <= |product[21:0];
          res.special <= 1'b0;
          res.req <= 1'b1;
          state <= mul_req;
        end
        mul_req: begin
          if (res.gnt) begin
            res.req <= 1'b0;
            state <= mul_idle;
          end
        end
        default: state <= mul_idle;
      endcase
    end
  end

endmodule

// ==== source/fp_result_arbiter.sv ====
// round-robin arbiter between the add and multiply cores
// the winner's result goes to the round stage, priority flips after each transfer
`timescale 1ns/1ps

module fp_result_arbiter #(
  parameter int TAG_W = 4
) (
  input  logic     clk,
  input  logic     rst,
  fp_result_if.arb add_res,
  fp_result_if.arb mul_res,
  fp_result_if.core out
);

  logic             prio_mul;
  logic             sel_mul;
  logic [TAG_W-1:0] win_tag;

  assign sel_mul = mul_res.req && (!add_res.req || prio_mul);
  assign win_tag = sel_mul ? mul_res.tag : add_res.tag;

  always_comb begin
    out.req = add_res.req | mul_res.req;
    out.tag = win_tag;
    if (sel_mul) begin
      out.special = mul_res.special;
      out.special_word = mul_res.special_word;
      out.sign = mul_res.sign;
      out.exp = mul_res.exp;
      out.mant = mul_res.mant;
      out.guard = mul_res.guard;
      out.round_bit = mul_res.round_bit;
      out.sticky = mul_res.sticky;
    end else begin
      out.special = add_res.special;
      out.special_word = add_res.special_word;
      out.sign = add_res.sign;
      out.exp = add_res.exp;
      out.mant = add_res.mant;
      out.guard = add_res.guard;
      out.round_bit = add_res.round_bit;
      out.sticky = add_res.sticky;
    end
  end

  // only the winner sees the grant
  assign add_res.gnt = out.gnt && !sel_mul;
  assign mul_res.gnt = out.gnt && sel_mul;

  always_ff @(posedge clk) begin
    if (rst) begin
      prio_mul <= 1'b0;
    end else if (out.req && out.gnt) begin
      prio_mul <= !sel_mul;
    end
  end

endmodule

// ==== source/fp_round_pack.sv ====
// shared normalise, round to nearest even and pack stage
// holds the packed word and its tag on the output until acknowledged
`timescale 1ns/1ps

module fp_round_pack import fp_pkg::*, fpu_ctrl_pkg::*; #(
  parameter int TAG_W = 4
) (
  input  logic             clk,
  input  logic             rst,
  input  logic             z_ack,
  fp_result_if.rnd         res,
  output fp_word_t         z,
  output logic [TAG_W-1:0] z_tag,
  output logic             z_stb
);

  localparam exp_t MIN_NORM_EXP = exp_t'(1 - EXP_BIAS);

  rp_state_e state;
  logic      z_s;
  exp_t      z_e;
  mant_t     z_m;
  logic      guard, round_bit, sticky;

  assign res.gnt = (state == rp_idle);

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= rp_idle;
      z_stb <= 1'b0;
    end else begin
      case (state)
        rp_idle: begin
          if (res.req) begin
            z_s <= res.sign;
            z_e <= res.exp;
            z_m <= res.mant;
            guard <= res.guard;
            round_bit <= res.round_bit;
            sticky <= res.sticky;
            z_tag <= res.tag;
            if (res.special) begin
              z <= res.special_word;
              z_stb <= 1'b1;
              state <= rp_put;
            end else begin
              state <= rp_norm_up;
            end
          end
        end
        rp_norm_up: begin
          if (!z_m[MANT_W] && z_e > MIN_NORM_EXP) begin
            z_e <= z_e - 10'sd1;
            z_m <= {z_m[MANT_W-1:0], guard};
            guard <= round_bit;
            round_bit <= 1'b0;
          end else begin
            state <= rp_norm_down;
          end
        end
        // denormalise results below the minimum exponent
        rp_norm_down: begin
          if (z_e < MIN_NORM_EXP) begin
            z_e <= z_e + 10'sd1;
            z_m <= z_m >> 1;
            guard <= z_m[0];
            round_bit <= guard;
            sticky <= sticky | round_bit;
          end else begin
            state <= rp_round;
          end
        end
        rp_round: begin
          if (guard && (round_bit | sticky | z_m[0])) begin
            z_m <= z_m + 1'b1;
            if (z_m == '1) begin
              z_e <= z_e + 10'sd1;
            end
          end
          state <= rp_pack;
        end
        rp_pack: begin
          if (z_e > exp_t'(EXP_BIAS)) begin
            z <= {z_s, EXP_MAX, {MANT_W{1'b0}}};
          end else if (z_e == MIN_NORM_EXP && !z_m[MANT_W]) begin
            z <= {z_s, 8'd0, z_m[MANT_W-1:0]};
          end else begin
            z <= {z_s, 8'(z_e + EXP_BIAS), z_m[MANT_W-1:0]};
          end
          z_stb <= 1'b1;
          state <= rp_put;
        end
        rp_put: begin
          if (z_ack) begin
            z_stb <= 1'b0;
            state <= rp_idle;
          end
        end
        default: state <= rp_idle;
      endcase
    end
  end

endmodule

// ==== source/fpu_top.sv ====
// single precision FPU with concurrent add and multiply cores
// results share one round stage and may leave out of order, matched by tag
`timescale 1ns/1ps

module fpu_top import fp_pkg::*, fpu_ctrl_pkg::*; #(
  parameter int TAG_W = 4
) (
  input  logic             clk,
  input  logic             rst,
  input  fpu_op_e          op,
  input  fp_word_t         a,
  input  fp_word_t         b,
  input  logic [TAG_W-1:0] tag,
  input  logic             in_stb,
  input  logic             z_ack,
  output logic             in_ack,
  output fp_word_t         z,
  output logic [TAG_W-1:0] z_tag,
  output logic             z_stb
);

  logic add_ready, mul_ready;
  logic add_start, mul_start;

  fp_result_if #(.TAG_W(TAG_W)) add_link ();
  fp_result_if #(.TAG_W(TAG_W)) mul_link ();
  fp_result_if #(.TAG_W(TAG_W)) rnd_link ();

  // accept only when the core for this opcode is free
  assign in_ack = (op == op_add) ? add_ready : mul_ready;
  assign add_start = in_stb && in_ack && (op == op_add);
  assign mul_start = in_stb && in_ack && (op == op_mul);

  fp_add_core #(.TAG_W(TAG_W)) u_add (
    .clk   (clk),
    .rst   (rst),
    .start (add_start),
    .a     (a),
    .b     (b),
    .tag   (tag),
    .idle  (add_ready),
    .res   (add_link.core)
  );

  fp_mul_core #(.TAG_W(TAG_W)) u_mul (
    .clk   (clk),
    .rst   (rst),
    .start (mul_start),
    .a     (a),
    .b     (b),
    .tag   (tag),
    .idle  (mul_ready),
    .res   (mul_link.core)
  );

  fp_result_arbiter #(.TAG_W(TAG_W)) u_arb (
    .clk     (clk),
    .rst     (rst),
    .add_res (add_link.arb),
    .mul_res (mul_link.arb),
    .out     (rnd_link.core)
  );

  fp_round_pack #(.TAG_W(TAG_W)) u_round (
    .clk   (clk),
    .rst   (rst),
    .z_ack (z_ack),
    .res   (rnd_link.rnd),
    .z     (z),
    .z_tag (z_tag),
    .z_stb (z_stb)
  );

endmodule

// ==== sim/fpu_props.sv ====
// output handshake properties of the FPU, bound into the top level
`timescale 1ns/1ps

module fpu_props #(
  parameter int TAG_W = 4
) (
  input logic             clk,
  input logic             rst,
  input logic [31:0]      z,
  input logic [TAG_W-1:0] z_tag,
  input logic             z_stb,
  input logic             z_ack
);

  // a stalled result keeps its word and tag
  hold_result: assert property (
    @(posedge clk) disable iff (rst) (z_stb && !z_ack) |=> ($stable(z) && $stable(z_tag))
  ) else $error("z or z_tag changed while the result was stalled");

  keep_strobe: assert property (
    @(posedge clk) disable iff (rst) (z_stb && !z_ack) |=> z_stb
  ) else $error("z_stb dropped before the result was acknowledged");

  reset_clears_strobe: assert property (
    @(posedge clk) rst |=> !z_stb
  ) else $error("z_stb high in the cycle after reset");

endmodule

bind fpu_top fpu_props #(.TAG_W(TAG_W)) u_props (
  .clk   (clk),
  .rst   (rst),
  .z     (z),
  .z_tag (z_tag),
  .z_stb (z_stb),
  .z_ack (z_ack)
);

// ==== sim/fpu_tb.sv ====
// testbench for the single precision FPU
// random add and multiply traffic checked against a wide integer model, matched by tag
`timescale 1ns/1ps

module fpu_tb import fpu_ctrl_pkg::*; ();

  localparam int TAG_W = 4;
  localparam int NUM_OPS = 400;
  localparam int CLK_PERIOD = 20;
  // serial bound per operation, long underflow shifts included
  localparam int WORST_CYCLES = 400;
  localparam int TIMEOUT_NS = (NUM_OPS + 8) * WORST_CYCLES * CLK_PERIOD;

  logic             clk;
  logic             rst;
  fpu_op_e          op;
  logic [31:0]      a, b;
  logic [TAG_W-1:0] tag;
  logic             in_stb;
  logic             z_ack;
  logic             in_ack;
  logic [31:0]      z;
  logic [TAG_W-1:0] z_tag;
  logic             z_stb;

  logic [31:0]      lfsr;
  logic [31:0]      expected [2**TAG_W];
  logic             pending [2**TAG_W];
  int               issued, retired, sent, issued_at_drive;
  int               value_errors, protocol_errors;
  logic             stalled;
  logic [31:0]      held_z;
  logic [TAG_W-1:0] held_tag;
  logic [TAG_W-1:0] next_tag;
  logic             b2b_checked;
  fpu_op_e          dir_op [$];
  logic [31:0]      dir_a [$];
  logic [31:0]      dir_b [$];

  fpu_top #(.TAG_W(TAG_W)) UUT (
    .clk    (clk),
    .rst    (rst),
    .op     (op),
    .a      (a),
    .b      (b),
    .tag    (tag),
    .in_stb (in_stb),
    .z_ack  (z_ack),
    .in_ack (in_ack),
    .z      (z),
    .z_tag  (z_tag),
    .z_stb  (z_stb)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // fibonacci LFSR, x^32 + x^22 + x^2 + x + 1, one step per bit
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      r = {r[30:0], fb};
    end
    return r;
  endfunction

  function automatic logic is_nan(input logic [31:0] w);
    return (w[30:23] == 8'hff) && (w[22:0] != '0);
  endfunction

  function automatic logic is_inf(input logic [31:0] w);
    return (w[30:23] == 8'hff) && (w[22:0] == '0);
  endfunction

  function automatic logic is_zero(input logic [31:0] w);
    return w[30:0] == '0;
  endfunction

  // value = m * 2^(e - 23)
  function automatic void split_word(input logic [31:0] w, output int e, output logic [23:0] m);
    if (w[30:23] == 8'd0) begin
      e = -126;
      m = {1'b0, w[22:0]};
    end else begin
      e = int'(w[30:23]) - 127;
      m = {1'b1, w[22:0]};
    end
  endfunction

  // round mag * 2^e to nearest even single precision
  function automatic logic [31:0] round_value(input logic s, input logic [127:0] mag, input int e);
    int           p, e_res, sh;
    logic [127:0] q;
    logic         g, st;
    if (mag == '0) return 32'h0;
    p = 0;
    for (int i = 0; i < 128; i++) begin
      if (mag[i]) p = i;
    end
    e_res = p + e;
    if (e_res < -126) e_res = -126;
    sh = e_res - 23 - e;
    if (sh > 100) sh = 100;
    if (sh > 0) begin
      q = mag >> sh;
      g = mag[sh-1];
      st = (mag & ((128'd1 << (sh - 1)) - 128'd1)) != '0;
    end else begin
      q = mag << (-sh);
      g = 1'b0;
      st = 1'b0;
    end
    if (g && (st || q[0])) q = q + 128'd1;
    if (q[24]) begin
      q = q >> 1;
      e_res++;
    end
    if (e_res > 127) return {s, 8'hff, 23'd0};
    if (!q[23]) return {s, 8'd0, q[22:0]};
    return {s, 8'(e_res + 127), q[22:0]};
  endfunction

  function automatic logic [31:0] add_model(input logic [31:0] x, input logic [31:0] y);
    int           ex, ey;
    logic [23:0]  mx, my;
    logic [127:0] big, lesser, mag;
    logic [31:0]  t;
    logic         s;
    if (is_nan(x) || is_nan(y)) return 32'hffc00000;
    if (is_inf(x)) return {x[31], 8'hff, 23'd0};
    if (is_inf(y)) return {y[31], 8'hff, 23'd0};
    if (is_zero(x) && is_zero(y)) return {x[31] & y[31], 31'd0};
    if (is_zero(x)) return y;
    if (is_zero(y)) return x;
    split_word(x, ex, mx);
    split_word(y, ey, my);
    if (ey > ex) begin
      t = x;
      x = y;
      y = t;
      split_word(x, ex, mx);
      split_word(y, ey, my);
    end
    big = 128'(mx) << 40;
    // far below the rounding point only its presence matters
    lesser = (ex - ey > 40) ? 128'(my != '0) : (128'(my) << (40 - (ex - ey)));
    if (x[31] == y[31]) begin
      mag = big + lesser;
      s = x[31];
    end else if (big >= lesser) begin
      mag = big - lesser;
      s = (big == lesser) ? 1'b0 : x[31];
    end else begin
      mag = lesser - big;
      s = y[31];
    end
    return round_value(s, mag, ex - 63);
  endfunction

  function automatic logic [31:0] mul_model(input logic [31:0] x, input logic [31:0] y);
    int          ex, ey;
    logic [23:0] mx, my;
    logic        s;
    s = x[31] ^ y[31];
    if (is_nan(x) || is_nan(y)) return 32'hffc00000;
    if ((is_inf(x) && is_zero(y)) || (is_zero(x) && is_inf(y))) return 32'hffc00000;
    if (is_inf(x) || is_inf(y)) return {s, 8'hff, 23'd0};
    if (is_zero(x) || is_zero(y)) return {s, 31'd0};
    split_word(x, ex, mx);
    split_word(y, ey, my);
    return round_value(s, 128'(mx) * 128'(my), ex + ey - 46);
  endfunction

  // a quarter of the operands get an edge exponent
  function automatic logic [31:0] rand_operand();
    logic [7:0]  e;
    logic [22:0] f;
    logic        s;
    s = 1'(take_bits(1));
    f = 23'(take_bits(23));
    if (take_bits(2) == 0) begin
      case (take_bits(2))
        0: begin
          e = 8'd0;
          if (take_bits(1)) f = '0;
        end
        1: begin
          e = 8'hff;
          if (take_bits(1)) f = '0;
        end
        2: e = 8'd250 + 8'(take_bits(2));
        default: e = 8'd1 + 8'(take_bits(2));
      endcase
    end else begin
      e = 8'd60 + 8'(take_bits(7));
    end
    return {s, e, f};
  endfunction

  task automatic queue_op(input fpu_op_e o, input logic [31:0] x, input logic [31:0] y);
    dir_op.push_back(o);
    dir_a.push_back(x);
    dir_b.push_back(y);
  endtask

  // accepts and retirements are both seen at the rising edge
  always @(posedge clk) begin
    if (!rst) begin
      if (in_stb && in_ack) begin
        expected[tag] = (op == op_add) ? add_model(a, b) : mul_model(a, b);
        pending[tag] = 1'b1;
        issued++;
      end
      if (stalled && z_stb) begin
        assert (z == held_z && z_tag == held_tag) else begin
          value_errors++;
          $display("ERROR z while stalled: got %h tag %h, held %h tag %h", z, z_tag, held_z,
                   held_tag);
        end
      end
      if (z_stb && z_ack) begin
        assert (pending[z_tag]) else begin
          protocol_errors++;
          $display("result came back with tag %h that was not outstanding", z_tag);
        end
        if (pending[z_tag]) begin
          assert (z == expected[z_tag]) else begin
            value_errors++;
            $display("ERROR z (tag %h): got %h, expected %h", z_tag, z, expected[z_tag]);
          end
        end
        pending[z_tag] = 1'b0;
        retired++;
      end
      stalled = z_stb && !z_ack;
      held_z = z;
      held_tag = z_tag;
    end
  end

  initial begin
    #(TIMEOUT_NS);
    $display("watchdog expired at %0t with %0d of %0d results back", $time, retired, NUM_OPS);
    $display("Checks failed");
    $finish;
  end

  initial begin
    lfsr = 32'h86ef;
    rst = 1'b1;
    op = op_add;
    a = '0;
    b = '0;
    tag = '0;
    in_stb = 1'b0;
    z_ack = 1'b0;
    issued = 0;
    retired = 0;
    sent = 0;
    issued_at_drive = 0;
    value_errors = 0;
    protocol_errors = 0;
    stalled = 1'b0;
    held_z = '0;
    held_tag = '0;
    next_tag = '0;
    b2b_checked = 1'b0;
    for (int i = 0; i < 2**TAG_W; i++) begin
      pending[i] = 1'b0;
      expected[i] = '0;
    end
    repeat (2) @(negedge clk);
    rst = 1'b0;
    #1;
    assert (!z_stb && in_ack) else begin
      protocol_errors++;
      $display("after reset z_stb is not low or in_ack is not high for add");
    end
    @(negedge clk);
    op = op_mul;
    #1;
    assert (in_ack) else begin
      protocol_errors++;
      $display("after reset in_ack is not high for multiply");
    end

    // add then multiply back to back, then the special cases
    queue_op(op_add, 32'h3f800000, 32'h40000000);
    queue_op(op_mul, 32'h40400000, 32'h3fc00000);
    queue_op(op_mul, 32'h7f800000, 32'h00000000);
    queue_op(op_mul, 32'h00000000, 32'hff800000);
    queue_op(op_add, 32'h00000000, 32'h40490fdb);
    queue_op(op_add, 32'h80000000, 32'h80000000);
    queue_op(op_add, 32'hff800000, 32'h3f800000);
    queue_op(op_mul, 32'h7fc00001, 32'h3f800000);
    queue_op(op_add, 32'h00000001, 32'h00000001);
    queue_op(op_mul, 32'h00400000, 32'h40000000);
    queue_op(op_add, 32'h3f800000, 32'hbf800000);
    queue_op(op_add, 32'h3f7fffff, 32'h33000000);
    queue_op(op_mul, 32'h7f000000, 32'h40000000);
    queue_op(op_mul, 32'h00800000, 32'h3e800000);

    while (retired < NUM_OPS) begin
      @(negedge clk);
      z_ack = take_bits(2) != 0;
      if (in_stb && issued != issued_at_drive) in_stb = 1'b0;
      if (!in_stb && sent < NUM_OPS && (dir_op.size() > 0 || take_bits(2) != 0)) begin
        while (pending[next_tag]) next_tag = next_tag + 1'b1;
        tag = next_tag;
        next_tag = next_tag + 1'b1;
        if (dir_op.size() > 0) begin
          op = dir_op.pop_front();
          a = dir_a.pop_front();
          b = dir_b.pop_front();
        end else begin
          op = take_bits(1) ? op_mul : op_add;
          a = rand_operand();
          b = rand_operand();
          // same exponent, opposite sign for cancellation
          if (op == op_add && take_bits(2) == 0) b = {~a[31], a[30:23], b[22:0]};
        end
        in_stb = 1'b1;
        issued_at_drive = issued;
        sent++;
      end
      if (issued >= 2 && !b2b_checked) begin
        b2b_checked = 1'b1;
        assert (retired == 0) else begin
          protocol_errors++;
          $display("a result left before the back to back add and multiply were both taken");
        end
      end
    end

    for (int i = 0; i < 2**TAG_W; i++) begin
      assert (!pending[i]) else begin
        protocol_errors++;
        $display("tag %0d never returned a result", i);
      end
    end
    $display("issued %0d, retired %0d, value errors %0d, protocol errors %0d", issued, retired,
             value_errors, protocol_errors);
    if (value_errors == 0 && protocol_errors == 0 && issued == NUM_OPS) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

// ==== build.f ====
source/fp_pkg.sv
source/fpu_ctrl_pkg.sv
source/fp_result_if.sv
source/fp_add_core.sv
source/fp_mul_core.sv
source/fp_result_arbiter.sv
source/fp_round_pack.sv
source/fpu_top.sv
sim/fpu_props.sv
sim/fpu_tb.sv

// ==== Makefile ====
# Verilator build and run of the FPU testbench

VERILATOR ?= verilator
TOP       ?= fpu_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(wildcard source/*.sv sim/*.sv)

.PHONY: all run lint clean

all: run

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# a crashed or aborted run is logged as a failure too
run: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || echo "Checks failed" >> $(LOG)
	cat $(LOG)
	@if grep -q "Checks failed" $(LOG); then echo "simulation failed, see $(LOG)"; exit 1; fi

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
